/* instrDecoder.f */
+incdir+rtl
rtl/decodePkg.sv
rtl/aluDecoder.sv
rtl/memDecoder.sv
rtl/branchUnit.sv
rtl/exceptionCheck.sv
rtl/instrDecoder.sv
sim/clockGen.sv
sim/instrDecoder_sva.sv
sim/instrDecoderTb.sv

/* sim/instrDecoderTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsIsa_defs.svh"

module instrDecoderTb;
	import decodePkg::*;

	typedef struct packed {
		logic [31:0] instr;
		logic        rsEqRt;
		logic [1:0]  rsSign;
		logic        fetchExc;
		logic [4:0]  fetchExcCode;
		logic [31:0] issue; // Cycle in which it was driven
	} inSetT;

	typedef struct packed {
		logic [4:0] aluOp;
		logic [2:0] mdOp;
		logic [1:0] extOp;
		logic       shamtSel;
		logic       regWrite;
		logic [1:0] dstSel;
		logic [2:0] wbSrc;
		logic       memRead;
		logic       memWrite;
		logic [2:0] memSize;
		logic [1:0] partialOp;
		logic [1:0] npcOp;
		logic       annulSlot;
		logic       inDelaySlot;
		logic       excValid;
		logic [4:0] excCode;
		logic       isBr; // Feeds the delay-slot flag of the next instruction
	} ctrlT;

	localparam int numInstr = 3000;

	localparam logic [5:0] keptOps [30] = '{
		`OP_J, `OP_JAL, `OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ,
		`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
		`OP_BEQL, `OP_BNEL, `OP_BLEZL, `OP_BGTZL,
		`OP_LB, `OP_LH, `OP_LWL, `OP_LW, `OP_LBU, `OP_LHU, `OP_LWR,
		`OP_SB, `OP_SH, `OP_SWL, `OP_SW, `OP_SWR
	};

	localparam logic [5:0] keptFns [28] = '{
		`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV,
		`FN_JR, `FN_JALR, `FN_SYSCALL, `FN_BREAK,
		`FN_MFHI, `FN_MTHI, `FN_MFLO, `FN_MTLO,
		`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU,
		`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_NOR,
		`FN_SLT, `FN_SLTU
	};

	// Opcode and funct of instructions outside the supported set
	localparam logic [11:0] droppedOps [8] = '{
		{6'b010000, 6'b011000}, // ERET
		{6'b011100, 6'b000010}, // MUL
		{6'b011100, 6'b100000}, // CLZ
		{6'b110000, 6'b000000}, // LL
		{6'b111000, 6'b000000}, // SC
		{6'b101111, 6'b000000}, // CACHE
		{`OP_SPECIAL, 6'b001010}, // MOVZ
		{`OP_SPECIAL, 6'b110100}  // TEQ
	};

	logic        clk;
	logic        rst;
	logic        instrValid;
	logic [31:0] instr;
	logic        rsEqRt;
	signT        rsSign;
	logic        fetchExc;
	logic [4:0]  fetchExcCode;
	logic        ctrlValid;
	aluOpT       aluOp;
	mdOpT        mdOp;
	extOpT       extOp;
	logic        shamtSel;
	logic        regWrite;
	dstSelT      dstSel;
	wbSrcT       wbSrc;
	logic        memRead;
	logic        memWrite;
	memSizeT     memSize;
	partialOpT   partialOp;
	npcOpT       npcOp;
	logic        annulSlot;
	logic        inDelaySlot;
	logic        excValid;
	excCodeT     excCode;

	integer      seed;
	int          errors = 0;
	int          checks = 0;
	int          resultNum = 0;
	logic [31:0] cycle = '0;
	logic        prevBr = 1'b0;
	inSetT       pending [$];

	clockGen i_clockGen (.clk(clk), .rst(rst));

	instrDecoder i_instrDecoder (
		.clk(clk), .rst(rst), .instrValid(instrValid), .instr(instr),
		.rsEqRt(rsEqRt), .rsSign(rsSign), .fetchExc(fetchExc), .fetchExcCode(fetchExcCode),
		.ctrlValid(ctrlValid), .aluOp(aluOp), .mdOp(mdOp), .extOp(extOp),
		.shamtSel(shamtSel), .regWrite(regWrite), .dstSel(dstSel), .wbSrc(wbSrc),
		.memRead(memRead), .memWrite(memWrite), .memSize(memSize), .partialOp(partialOp),
		.npcOp(npcOp), .annulSlot(annulSlot), .inDelaySlot(inDelaySlot),
		.excValid(excValid), .excCode(excCode)
	);

	always @(posedge clk)
		cycle <= cycle + 1;

	function automatic logic [31:0] makeInstr(input logic [31:0] r, input logic [31:0] f);
		logic [31:0] w;
		logic [11:0] d;
		logic        tidy;
		w    = f;
		tidy = (r[30:28] != 3'd0); // One in eight keeps random spare fields
		case (r % 10)
			0, 1, 2: begin
				w[31:26] = `OP_SPECIAL;
				w[5:0]   = keptFns[r[15:4] % 28];
				if (tidy) begin
					if (w[5:0] inside {`FN_SLL, `FN_SRL, `FN_SRA})
						w[25:21] = 5'd0;
					else
						w[10:6] = 5'd0;
					if (w[5:0] inside {`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU,
						`FN_MTHI, `FN_MTLO, `FN_JR})
						w[15:11] = 5'd0;
				end
			end
			3, 4, 5, 6: begin
				w[31:26] = keptOps[r[15:4] % 30];
				if (tidy && (w[31:26] inside {`OP_BLEZ, `OP_BGTZ, `OP_BLEZL, `OP_BGTZL}))
					w[20:16] = 5'd0;
			end
			7: begin
				w[31:26] = `OP_REGIMM;
				if (tidy)
					w[19:18] = 2'b00; // Lands on one of the eight branch forms
			end
			8: begin
				d        = droppedOps[r[15:4] % 8];
				w[31:26] = d[11:6];
				w[5:0]   = d[5:0];
			end
			default: w = f;
		endcase
		return w;
	endfunction

	function automatic ctrlT decodeRef(input inSetT s, input logic prevFlag);
		ctrlT       e;
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rt;
		logic       special;
		logic       aluKnown;
		logic       aluWr;
		logic       memRd;
		logic       memWr;
		logic       condBr;
		logic       taken;
		logic       likely;
		logic       jump;
		logic       link;
		logic       badField;
		logic       brk;
		logic       sys;
		op            = s.instr[31:26];
		fn            = s.instr[5:0];
		rt            = s.instr[20:16];
		special       = (op == `OP_SPECIAL);
		e             = '0;
		e.aluOp       = aluNone;
		e.memSize     = memWord;
		e.inDelaySlot = prevFlag;
		{memRd, memWr, condBr, taken, jump, link} = '0;

		if (special) begin
			e.dstSel = dstRd;
			case (fn)
				`FN_ADD:            e.aluOp = aluAdd;
				`FN_ADDU:           e.aluOp = aluAddu;
				`FN_SUB:            e.aluOp = aluSub;
				`FN_SUBU:           e.aluOp = aluSubu;
				`FN_AND:            e.aluOp = aluAnd;
				`FN_OR:             e.aluOp = aluOr;
				`FN_XOR:            e.aluOp = aluXor;
				`FN_NOR:            e.aluOp = aluNor;
				`FN_SLT:            e.aluOp = aluSlt;
				`FN_SLTU:           e.aluOp = aluSltu;
				`FN_SLL, `FN_SLLV:  e.aluOp = aluSll;
				`FN_SRL, `FN_SRLV:  e.aluOp = aluSrl;
				`FN_SRA, `FN_SRAV:  e.aluOp = aluSra;
				`FN_MFHI, `FN_MFLO: e.wbSrc = wbHiLo;
				`FN_MULT:           e.mdOp = mdMult;
				`FN_MULTU:          e.mdOp = mdMultu;
				`FN_DIV:            e.mdOp = mdDiv;
				`FN_DIVU:           e.mdOp = mdDivu;
				`FN_MTHI:           e.mdOp = mdMthi;
				`FN_MTLO:           e.mdOp = mdMtlo;
				default: ;
			endcase
			e.shamtSel = (fn == `FN_SLL) || (fn == `FN_SRL) || (fn == `FN_SRA);
			aluWr      = (e.aluOp != aluNone) || (e.wbSrc == wbHiLo);
			aluKnown   = aluWr || (e.mdOp != mdNone); // HI/LO only, no GPR write
		end else begin
			case (op)
				`OP_ADDI:  {e.aluOp, e.extOp} = {aluAdd, extSign};
				`OP_ADDIU: {e.aluOp, e.extOp} = {aluAddu, extSign};
				`OP_SLTI:  {e.aluOp, e.extOp} = {aluSlt, extSign};
				`OP_SLTIU: {e.aluOp, e.extOp} = {aluSltu, extSign};
				`OP_ANDI:  e.aluOp = aluAnd;
				`OP_ORI:   e.aluOp = aluOr;
				`OP_XORI:  e.aluOp = aluXor;
				`OP_LUI:   {e.wbSrc, e.extOp} = {wbImm, extLui};
				default: ;
			endcase
			aluKnown = (e.aluOp != aluNone) || (e.wbSrc == wbImm);
			aluWr    = aluKnown && (rt != 5'd0); // Writes to $zero vanish
		end

		case (op)
			`OP_LB:  {memRd, e.memSize} = {1'b1, memByte};
			`OP_LBU: {memRd, e.memSize} = {1'b1, memByteU};
			`OP_LH:  {memRd, e.memSize} = {1'b1, memHalf};
			`OP_LHU: {memRd, e.memSize} = {1'b1, memHalfU};
			`OP_LW:  memRd = 1'b1;
			`OP_LWL: {memRd, e.partialOp} = {1'b1, partLeft};
			`OP_LWR: {memRd, e.partialOp} = {1'b1, partRight};
			`OP_SB:  {memWr, e.memSize} = {1'b1, memByte};
			`OP_SH:  {memWr, e.memSize} = {1'b1, memHalf};
			`OP_SW:  memWr = 1'b1;
			`OP_SWL: {memWr, e.partialOp} = {1'b1, partLeft};
			`OP_SWR: {memWr, e.partialOp} = {1'b1, partRight};
			default: ;
		endcase
		if (memRd || memWr)
			{e.aluOp, e.extOp} = {aluAdd, extSign}; // Base plus signed offset
		if (memRd)
			{e.dstSel, e.wbSrc} = {dstRt, wbMem};

		case (op)
			`OP_BEQ, `OP_BEQL:   {condBr, taken} = {1'b1, s.rsEqRt};
			`OP_BNE, `OP_BNEL:   {condBr, taken} = {1'b1, !s.rsEqRt};
			`OP_BLEZ, `OP_BLEZL: {condBr, taken} = {rt == 5'd0, s.rsSign != signPos};
			`OP_BGTZ, `OP_BGTZL: {condBr, taken} = {rt == 5'd0, s.rsSign == signPos};
			`OP_REGIMM: begin
				condBr = (rt[3:2] == 2'b00);
				taken  = rt[0] ? (s.rsSign != signNeg) : (s.rsSign == signNeg);
				link   = condBr && rt[4];
			end
			`OP_J:   jump = 1'b1;
			`OP_JAL: {jump, link} = 2'b11;
			`OP_SPECIAL: begin
				if ((fn == `FN_JR) || (fn == `FN_JALR))
					{jump, link} = {1'b1, fn == `FN_JALR};
			end
			default: ;
		endcase
		likely = (op[5:2] == 4'b0101) || ((op == `OP_REGIMM) && rt[1]);
		if (condBr && taken)
			e.npcOp = npcBranch;
		else if (jump)
			e.npcOp = special ? npcJumpReg : npcJump;
		e.annulSlot = condBr && likely && !taken;
		e.isBr      = condBr || jump;
		if (link)
			{e.dstSel, e.wbSrc} = {special ? dstRd : dstLink31, wbLink};

		// Unused SPECIAL fields must be zero
		badField = special && ((e.shamtSel && (s.instr[25:21] != 5'd0)) ||
			(!e.shamtSel && (aluKnown || jump) && (s.instr[10:6] != 5'd0)) ||
			(((e.mdOp != mdNone) || (fn == `FN_JR)) && (s.instr[15:11] != 5'd0)));
		brk = special && (fn == `FN_BREAK);
		sys = special && (fn == `FN_SYSCALL);

		e.excValid = 1'b1;
		if (s.fetchExc)
			e.excCode = s.fetchExcCode;
		else if (!(((aluKnown || e.isBr) && !badField) || memRd || memWr || brk || sys))
			e.excCode = excRI;
		else if (brk)
			e.excCode = excBp;
		else if (sys)
			e.excCode = excSys;
		else
			e.excValid = 1'b0;

		e.regWrite = !e.excValid && (aluWr || memRd || link);
		e.memRead  = memRd;
		e.memWrite = memWr && !e.excValid;
		return e;
	endfunction

	task automatic checkField(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		checks++;
		if (actVal !== expVal) begin
			errors++;
			$display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
		end
	endtask

	task automatic compareWord(input int n, input ctrlT e);
		string t;
		t = $sformatf("instr %0d", n);
		checkField({t, " aluOp"}, e.aluOp, aluOp);
		checkField({t, " mdOp"}, e.mdOp, mdOp);
		checkField({t, " extOp"}, e.extOp, extOp);
		checkField({t, " shamtSel"}, e.shamtSel, shamtSel);
		checkField({t, " regWrite"}, e.regWrite, regWrite);
		checkField({t, " dstSel"}, e.dstSel, dstSel);
		checkField({t, " wbSrc"}, e.wbSrc, wbSrc);
		checkField({t, " memRead"}, e.memRead, memRead);
		checkField({t, " memWrite"}, e.memWrite, memWrite);
		checkField({t, " memSize"}, e.memSize, memSize);
		checkField({t, " partialOp"}, e.partialOp, partialOp);
		checkField({t, " npcOp"}, e.npcOp, npcOp);
		checkField({t, " annulSlot"}, e.annulSlot, annulSlot);
		checkField({t, " inDelaySlot"}, e.inDelaySlot, inDelaySlot);
		checkField({t, " excValid"}, e.excValid, excValid);
		checkField({t, " excCode"}, e.excCode, excCode);
	endtask

	// Sample half a cycle after the edge, where the register is stable
	always @(negedge clk) begin : compareProc
		inSetT s;
		ctrlT  e;
		string t;
		if (cycle != 0) begin
			if (ctrlValid) begin
				if (pending.size() == 0) begin
					errors++;
					$display("ctrlValid was high in cycle %0d with no instruction pending", cycle);
				end else begin
					s = pending.pop_front();
					if (cycle != s.issue + 1) begin
						errors++;
						$display("Result issued in cycle %0d arrived in cycle %0d", s.issue, cycle);
					end
					e      = decodeRef(s, prevBr);
					prevBr = e.isBr;
					compareWord(resultNum, e);
					resultNum++;
				end
			end else begin
				t = $sformatf("idle cycle %0d", cycle);
				checkField({t, " regWrite"}, 0, regWrite);
				checkField({t, " memRead"}, 0, memRead);
				checkField({t, " memWrite"}, 0, memWrite);
				checkField({t, " excValid"}, 0, excValid);
				if (!rst) begin
					checkField({t, " annulSlot"}, 0, annulSlot);
					checkField({t, " inDelaySlot"}, 0, inDelaySlot);
					checkField({t, " npcOp"}, npcSeq, npcOp);
				end
			end
		end
	end

	// Valid traffic under reset must leave every control cleared
	task automatic driveDuringReset();
		for (int i = 0; (i < 4) && (rst !== 1'b1); i++) begin
			instrValid = 1'b1;
			case (i)
				0: begin
					instr  = {`OP_REGIMM, 5'd1, `RT_BGEZALL, 16'h0010}; // Untaken likely link
					rsSign = signNeg;
				end
				1: instr = {`OP_LW, 5'd2, 5'd3, 16'h0004};
				2: instr = {`OP_SW, 5'd2, 5'd3, 16'h0008};
				default: begin
					instr        = {`OP_BEQ, 5'd1, 5'd1, 16'h0020};
					rsEqRt       = 1'b1; // Taken
					fetchExc     = 1'b1;
					fetchExcCode = 5'd4;
				end
			endcase
			@(posedge clk);
			#1;
		end
		instrValid   = 1'b0;
		rsEqRt       = 1'b0;
		rsSign       = signZero;
		fetchExc     = 1'b0;
		fetchExcCode = '0;
	endtask

	task automatic driveRandom();
		logic [31:0] r;
		inSetT       s;
		for (int i = 0; i < numInstr; i++) begin
			@(posedge clk);
			#1;
			r = $random(seed);
			if (r[2:0] == 3'd0) begin
				instrValid = 1'b0; // Bubble
				instr      = $random(seed);
			end else begin
				s.instr        = makeInstr($random(seed), $random(seed));
				s.rsEqRt       = r[3];
				s.rsSign       = r[7:4] % 3;
				s.fetchExc     = (r[11:8] == 4'd0);
				s.fetchExcCode = 5'd1 + r[16:12] % 31; // Never zero
				s.issue        = cycle;
				instrValid     = 1'b1;
				instr          = s.instr;
				rsEqRt         = s.rsEqRt;
				rsSign         = signT'(s.rsSign);
				fetchExc       = s.fetchExc;
				fetchExcCode   = s.fetchExcCode;
				pending.push_back(s);
			end
		end
		@(posedge clk);
		#1;
		instrValid = 1'b0;
	endtask

	initial begin
		int n;
		seed         = 55;
		instrValid   = 1'b0;
		instr        = '0;
		rsEqRt       = 1'b0;
		rsSign       = signZero;
		fetchExc     = 1'b0;
		fetchExcCode = '0;

		driveDuringReset();
		for (n = 0; (n < 50) && (rst !== 1'b1); n++)
			@(posedge clk);
		if (rst !== 1'b1) begin
			errors++;
			$display("Timeout: reset was not released within 50 cycles");
		end else begin
			driveRandom();
			for (n = 0; (n < 20) && (pending.size() != 0); n++)
				@(posedge clk);
			if (pending.size() != 0) begin
				errors++;
				$display("Timeout: %0d instructions never produced ctrlValid", pending.size());
			end
		end

		$display("Results: %0d, field checks: %0d, errors: %0d", resultNum, checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/instrDecoder_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder_sva (
	input wire logic             clk,
	input wire logic             rst,
	input wire logic             instrValid,
	input wire logic             ctrlValid,
	input wire logic             regWrite,
	input wire logic             memRead,
	input wire logic             memWrite,
	input wire logic             excValid,
	input wire logic             annulSlot,
	input wire decodePkg::npcOpT npcOp
);
	import decodePkg::*;

	// Registered word appears exactly one cycle after the instruction
	ctrlLatency: assert property (@(posedge clk) disable iff (!rst)
		$past(rst) |-> (ctrlValid == $past(instrValid)))
		else $error("ctrlValid does not follow instrValid by one cycle");

	memExclusive: assert property (@(posedge clk) disable iff (!rst)
		!(memRead && memWrite))
		else $error("memRead and memWrite are both high");

	excNoWrite: assert property (@(posedge clk) disable iff (!rst)
		excValid |-> (!regWrite && !memWrite))
		else $error("Excepting instruction still writes");

	annulNoRedirect: assert property (@(posedge clk) disable iff (!rst)
		annulSlot |-> (npcOp == npcSeq))
		else $error("annulSlot raised with a redirecting npcOp");

endmodule

bind instrDecoder instrDecoder_sva i_instrDecoderSva (
	.clk(clk), .rst(rst), .instrValid(instrValid), .ctrlValid(ctrlValid),
	.regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
	.excValid(excValid), .annulSlot(annulSlot), .npcOp(npcOp)
);

`default_nettype wire

/* sim/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
	parameter int halfPeriod  = 2,
	parameter int resetCycles = 5
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	// Active-low reset, released just after an edge
	initial begin
		rst = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#1 rst = 1'b1;
	end

endmodule

`default_nettype wire

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsIsa_defs.svh"

module instrDecoder (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                instrValid,
	input  wire logic [`INSTR_W-1:0] instr,
	input  wire logic                rsEqRt,
	input  wire decodePkg::signT     rsSign,
	input  wire logic                fetchExc,
	input  wire logic [`EXC_W-1:0]   fetchExcCode,
	output logic                     ctrlValid,
	output decodePkg::aluOpT         aluOp,
	output decodePkg::mdOpT          mdOp,
	output decodePkg::extOpT         extOp,
	output logic                     shamtSel,
	output logic                     regWrite,
	output decodePkg::dstSelT        dstSel,
	output decodePkg::wbSrcT         wbSrc,
	output logic                     memRead,
	output logic                     memWrite,
	output decodePkg::memSizeT       memSize,
	output decodePkg::partialOpT     partialOp,
	output decodePkg::npcOpT         npcOp,
	output logic                     annulSlot,
	output logic                     inDelaySlot,
	output logic                     excValid,
	output decodePkg::excCodeT       excCode
);
	import decodePkg::*;

	logic [`OP_W-1:0]    op;
	logic [`REG_W-1:0]   rs;
	logic [`REG_W-1:0]   rt;
	logic [`REG_W-1:0]   rd;
	logic [`REG_W-1:0]   shamt;
	logic [`FUNCT_W-1:0] funct;

	aluOpT     aluOpDec;
	mdOpT      mdOpDec;
	extOpT     extOpDec;
	logic      shamtSelDec;
	dstSelT    dstSelAlu;
	wbSrcT     wbSrcAlu;
	logic      aluWrite;
	logic      aluKnown;
	logic      memReadDec;
	logic      memWriteDec;
	memSizeT   memSizeDec;
	partialOpT partialOpDec;
	logic      memKnown;
	npcOpT     npcOpDec;
	logic      annulDec;
	logic      linkWrite;
	logic      isBranch;
	logic      slotFlag;
	logic      branchKnown;
	logic      excValidDec;
	excCodeT   excCodeDec;

	logic      rdUnused;
	logic      fieldErr;
	logic      jalr;
	aluOpT     aluOpSel;
	extOpT     extOpSel;
	dstSelT    dstSelSel;
	wbSrcT     wbSrcSel;
	logic      regWriteDec;

	assign op    = instr[31:26];
	assign rs    = instr[25:21];
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];
	assign shamt = instr[10:6];
	assign funct = instr[5:0];

	aluDecoder i_aluDecoder (
		.op(op), .funct(funct), .rt(rt),
		.aluOp(aluOpDec), .mdOp(mdOpDec), .extOp(extOpDec), .shamtSel(shamtSelDec),
		.dstSel(dstSelAlu), .wbSrc(wbSrcAlu), .aluWrite(aluWrite), .known(aluKnown)
	);

	memDecoder i_memDecoder (
		.op(op), .memRead(memReadDec), .memWrite(memWriteDec), .memSize(memSizeDec),
		.partialOp(partialOpDec), .known(memKnown)
	);

	branchUnit i_branchUnit (
		.clk(clk), .rst(rst), .instrValid(instrValid), .op(op), .funct(funct), .rt(rt),
		.rsEqRt(rsEqRt), .rsSign(rsSign), .npcOp(npcOpDec), .annulSlot(annulDec),
		.linkWrite(linkWrite), .isBranch(isBranch), .inDelaySlot(slotFlag),
		.known(branchKnown)
	);

	// SPECIAL forms keep unused rs, rd and shamt fields at zero
	assign rdUnused = (mdOpDec != mdNone) || ((npcOpDec == npcJumpReg) && !linkWrite);
	assign fieldErr = (op == `OP_SPECIAL) &&
		((shamtSelDec && (rs != '0)) ||
		(!shamtSelDec && (aluKnown || isBranch) && (shamt != '0)) ||
		(rdUnused && (rd != '0)));

	exceptionCheck i_exceptionCheck (
		.instrValid(instrValid), .op(op), .funct(funct),
		.fetchExc(fetchExc), .fetchExcCode(fetchExcCode),
		.aluKnown(aluKnown && !fieldErr), .memKnown(memKnown),
		.branchKnown(branchKnown && !fieldErr),
		.excValid(excValidDec), .excCode(excCodeDec)
	);

	assign jalr = linkWrite && (npcOpDec == npcJumpReg);

	always_comb begin
		aluOpSel  = aluOpDec;
		extOpSel  = extOpDec;
		dstSelSel = dstSelAlu;
		wbSrcSel  = wbSrcAlu;
		if (memKnown) begin
			aluOpSel = aluAdd; // Address is base plus offset
			extOpSel = extSign;
		end
		if (memReadDec) begin
			dstSelSel = dstRt;
			wbSrcSel  = wbMem;
		end else if (linkWrite) begin
			dstSelSel = jalr ? dstRd : dstLink31;
			wbSrcSel  = wbLink;
		end
	end

	assign regWriteDec = instrValid && !excValidDec && (aluWrite || memReadDec || linkWrite);

	always_ff @(posedge clk) begin
		if (!rst) begin
			ctrlValid   <= 1'b0;
			regWrite    <= 1'b0;
			memRead     <= 1'b0;
			memWrite    <= 1'b0;
			excValid    <= 1'b0;
			annulSlot   <= 1'b0;
			inDelaySlot <= 1'b0;
			npcOp       <= npcSeq;
		end else begin
			ctrlValid   <= instrValid;
			regWrite    <= regWriteDec;
			memRead     <= instrValid && memReadDec;
			memWrite    <= instrValid && !excValidDec && memWriteDec;
			excValid    <= excValidDec;
			annulSlot   <= instrValid && annulDec;
			inDelaySlot <= slotFlag;
			npcOp       <= instrValid ? npcOpDec : npcSeq; // Bubbles never redirect
		end
	end

	always_ff @(posedge clk) begin
		aluOp     <= aluOpSel;
		mdOp      <= mdOpDec;
		extOp     <= extOpSel;
		shamtSel  <= shamtSelDec;
		dstSel    <= dstSelSel;
		wbSrc     <= wbSrcSel;
		memSize   <= memSizeDec;
		partialOp <= partialOpDec;
		excCode   <= excCodeDec;
	end

endmodule

`default_nettype wire

/* rtl/exceptionCheck.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsIsa_defs.svh"

module exceptionCheck (
	input  wire logic                instrValid,
	input  wire logic [`OP_W-1:0]    op,
	input  wire logic [`FUNCT_W-1:0] funct,
	input  wire logic                fetchExc,
	input  wire logic [`EXC_W-1:0]   fetchExcCode,
	input  wire logic                aluKnown,
	input  wire logic                memKnown,
	input  wire logic                branchKnown,
	output logic                     excValid,
	output decodePkg::excCodeT       excCode
);
	import decodePkg::*;

	logic isBreak;
	logic isSyscall;
	logic reserved;

	assign isBreak   = (op == `OP_SPECIAL) && (funct == `FN_BREAK);
	assign isSyscall = (op == `OP_SPECIAL) && (funct == `FN_SYSCALL);
	// Nobody claims it
	assign reserved  = !(aluKnown || memKnown || branchKnown || isBreak || isSyscall);

	always_comb begin
		excValid = 1'b1;
		excCode  = excNone;
		if (!instrValid)
			excValid = 1'b0;
		else if (fetchExc)
			excCode = excCodeT'(fetchExcCode); // Fetch code kept as is
		else if (reserved)
			excCode = excRI;
		else if (isBreak)
			excCode = excBp;
		else if (isSyscall)
			excCode = excSys;
		else
			excValid = 1'b0;
	end

endmodule

`default_nettype wire

/* rtl/branchUnit.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsIsa_defs.svh"

module branchUnit (
	input  wire logic                clk,
	input  wire logic                rst,
	input  wire logic                instrValid,
	input  wire logic [`OP_W-1:0]    op,
	input  wire logic [`FUNCT_W-1:0] funct,
	input  wire logic [`REG_W-1:0]   rt,
	input  wire logic                rsEqRt,
	input  wire decodePkg::signT     rsSign,
	output decodePkg::npcOpT         npcOp,
	output logic                     annulSlot,
	output logic                     linkWrite,
	output logic                     isBranch,
	output logic                     inDelaySlot,
	output logic                     known
);
	import decodePkg::*;

	logic condBr; // Conditional branch recognised
	logic taken;
	logic likely;
	logic isJump;

	always_comb begin
		condBr    = 1'b0;
		taken     = 1'b0;
		likely    = 1'b0;
		isJump    = 1'b0;
		linkWrite = 1'b0;
		npcOp     = npcSeq;
		case (op)
			`OP_BEQ, `OP_BEQL: begin
				condBr = 1'b1;
				taken  = rsEqRt;
				likely = op[4];
			end
			`OP_BNE, `OP_BNEL: begin
				condBr = 1'b1;
				taken  = !rsEqRt;
				likely = op[4];
			end
			`OP_BLEZ, `OP_BLEZL, `OP_BGTZ, `OP_BGTZL: begin
				condBr = (rt == '0); // rt field must be zero
				taken  = op[0] ? (rsSign == signPos) : (rsSign != signPos);
				likely = op[4];
			end
			`OP_REGIMM: begin
				case (rt)
					`RT_BLTZ, `RT_BGEZ, `RT_BLTZL, `RT_BGEZL,
					`RT_BLTZAL, `RT_BGEZAL, `RT_BLTZALL, `RT_BGEZALL: condBr = 1'b1;
					default: condBr = 1'b0;
				endcase
				taken     = rt[0] ? (rsSign != signNeg) : (rsSign == signNeg);
				likely    = rt[1];
				linkWrite = condBr && rt[4]; // Link even when not taken
			end
			`OP_J, `OP_JAL: begin
				isJump    = 1'b1;
				npcOp     = npcJump;
				linkWrite = op[0];
			end
			`OP_SPECIAL: begin
				if ((funct == `FN_JR) || (funct == `FN_JALR)) begin
					isJump    = 1'b1;
					npcOp     = npcJumpReg;
					linkWrite = funct[0]; // JALR
				end
			end
			default: condBr = 1'b0;
		endcase

		if (condBr && taken)
			npcOp = npcBranch;
		annulSlot = condBr && likely && !taken;
	end

	assign isBranch = condBr || isJump;
	assign known    = isBranch;

	// Next accepted instruction sits in the delay slot
	always_ff @(posedge clk) begin
		if (!rst)
			inDelaySlot <= 1'b0;
		else if (instrValid)
			inDelaySlot <= isBranch;
	end

endmodule

`default_nettype wire

/* rtl/memDecoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsIsa_defs.svh"

module memDecoder (
	input  wire logic [`OP_W-1:0] op,
	output logic                  memRead,
	output logic                  memWrite,
	output decodePkg::memSizeT    memSize,
	output decodePkg::partialOpT  partialOp,
	output logic                  known
);
	import decodePkg::*;

	always_comb begin
		memRead   = 1'b0;
		memWrite  = 1'b0;
		memSize   = memWord;
		partialOp = partNone;
		case (op)
			`OP_LB:  memRead = 1'b1;
			`OP_LBU: memRead = 1'b1;
			`OP_LH:  memRead = 1'b1;
			`OP_LHU: memRead = 1'b1;
			`OP_LW:  memRead = 1'b1;
			`OP_LWL: memRead = 1'b1;
			`OP_LWR: memRead = 1'b1;
			`OP_SB:  memWrite = 1'b1;
			`OP_SH:  memWrite = 1'b1;
			`OP_SW:  memWrite = 1'b1;
			`OP_SWL: memWrite = 1'b1;
			`OP_SWR: memWrite = 1'b1;
			default: memRead = 1'b0;
		endcase

		case (op)
			`OP_LB, `OP_SB: memSize = memByte;
			`OP_LBU:        memSize = memByteU;
			`OP_LH, `OP_SH: memSize = memHalf;
			`OP_LHU:        memSize = memHalfU;
			default:        memSize = memWord; // Word and unaligned forms
		endcase

		if ((op == `OP_LWL) || (op == `OP_SWL))
			partialOp = partLeft;
		else if ((op == `OP_LWR) || (op == `OP_SWR))
			partialOp = partRight;
	end

	assign known = memRead || memWrite;

endmodule

`default_nettype wire

/* rtl/aluDecoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mipsIsa_defs.svh"

module aluDecoder (
	input  wire logic [`OP_W-1:0]    op,
	input  wire logic [`FUNCT_W-1:0] funct,
	input  wire logic [`REG_W-1:0]   rt,
	output decodePkg::aluOpT         aluOp,
	output decodePkg::mdOpT          mdOp,
	output decodePkg::extOpT         extOp,
	output logic                     shamtSel,
	output decodePkg::dstSelT        dstSel,
	output decodePkg::wbSrcT         wbSrc,
	output logic                     aluWrite,
	output logic                     known
);
	import decodePkg::*;

	always_comb begin
		aluOp    = aluNone;
		mdOp     = mdNone;
		shamtSel = 1'b0;
		dstSel   = dstRt;
		wbSrc    = wbAlu;
		case (op)
			`OP_SPECIAL: begin
				case (funct)
					`FN_ADD:            aluOp = aluAdd;
					`FN_ADDU:           aluOp = aluAddu;
					`FN_SUB:            aluOp = aluSub;
					`FN_SUBU:           aluOp = aluSubu;
					`FN_AND:            aluOp = aluAnd;
					`FN_OR:             aluOp = aluOr;
					`FN_XOR:            aluOp = aluXor;
					`FN_NOR:            aluOp = aluNor;
					`FN_SLT:            aluOp = aluSlt;
					`FN_SLTU:           aluOp = aluSltu;
					`FN_SLL, `FN_SLLV:  aluOp = aluSll;
					`FN_SRL, `FN_SRLV:  aluOp = aluSrl;
					`FN_SRA, `FN_SRAV:  aluOp = aluSra;
					`FN_MFHI, `FN_MFLO: wbSrc = wbHiLo;
					`FN_MULT:           mdOp = mdMult;
					`FN_MULTU:          mdOp = mdMultu;
					`FN_DIV:            mdOp = mdDiv;
					`FN_DIVU:           mdOp = mdDivu;
					`FN_MTHI:           mdOp = mdMthi;
					`FN_MTLO:           mdOp = mdMtlo;
					default:            aluOp = aluNone; // JR, BREAK etc. handled elsewhere
				endcase
				shamtSel = (funct == `FN_SLL) || (funct == `FN_SRL) || (funct == `FN_SRA);
				dstSel   = dstRd;
			end
			`OP_ADDI:  aluOp = aluAdd;
			`OP_ADDIU: aluOp = aluAddu;
			`OP_SLTI:  aluOp = aluSlt;
			`OP_SLTIU: aluOp = aluSltu;
			`OP_ANDI:  aluOp = aluAnd;
			`OP_ORI:   aluOp = aluOr;
			`OP_XORI:  aluOp = aluXor;
			`OP_LUI:   wbSrc = wbImm; // Shifted immediate goes straight to the register
			default:   aluOp = aluNone;
		endcase

		if (op == `OP_SPECIAL) begin
			aluWrite = (aluOp != aluNone) || (wbSrc == wbHiLo);
			known    = aluWrite || (mdOp != mdNone); // HI/LO writers leave aluWrite low
		end else begin
			known    = (aluOp != aluNone) || (wbSrc == wbImm);
			aluWrite = known && (rt != '0); // Results aimed at $zero are dropped
		end
	end

	always_comb begin
		case (op)
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU: extOp = extSign;
			`OP_LUI:                                  extOp = extLui;
			default:                                  extOp = extZero; // Logical immediates
		endcase
	end

endmodule

`default_nettype wire

/* rtl/decodePkg.sv */
`default_nettype none
`include "mipsIsa_defs.svh"

package decodePkg;

	typedef enum logic [4:0] {
		aluAdd,
		aluAddu,
		aluSub,
		aluSubu,
		aluOr,
		aluAnd,
		aluNor,
		aluXor,
		aluSll, // Also SLLV
		aluSrl,
		aluSra,
		aluSlt,
		aluSltu,
		aluNone
	} aluOpT;

	typedef enum logic [2:0] {
		mdNone,
		mdMult,
		mdMultu,
		mdDiv,
		mdDivu,
		mdMthi,
		mdMtlo
	} mdOpT;

	typedef enum logic [1:0] {extZero, extSign, extLui} extOpT;

	typedef enum logic [1:0] {dstRt, dstRd, dstLink31} dstSelT;

	typedef enum logic [2:0] {wbAlu, wbHiLo, wbImm, wbLink, wbMem} wbSrcT;

	typedef enum logic [2:0] {memByte, memByteU, memHalf, memHalfU, memWord} memSizeT;

	// LWL/SWL and LWR/SWR
	typedef enum logic [1:0] {partNone, partLeft, partRight} partialOpT;

	typedef enum logic [1:0] {npcSeq, npcBranch, npcJump, npcJumpReg} npcOpT;

	// Sign of rs from the comparator
	typedef enum logic [1:0] {signZero, signPos, signNeg} signT;

	// MIPS Cause codes; fetch-stage codes arrive as raw values
	typedef enum logic [`EXC_W-1:0] {
		excNone = 5'd0,
		excSys  = 5'd8,
		excBp   = 5'd9,
		excRI   = 5'd10
	} excCodeT;

endpackage

`default_nettype wire

/* rtl/mipsIsa_defs.svh */
`ifndef MIPS_ISA_DEFS_SVH
`define MIPS_ISA_DEFS_SVH

// Field widths
`define INSTR_W 32
`define OP_W    6
`define FUNCT_W 6
`define REG_W   5
`define EXC_W   5

// Primary opcodes
`define OP_SPECIAL 6'b000000
`define OP_REGIMM  6'b000001
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_BLEZ    6'b000110
`define OP_BGTZ    6'b000111
`define OP_ADDI    6'b001000
`define OP_ADDIU   6'b001001
`define OP_SLTI    6'b001010
`define OP_SLTIU   6'b001011
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111
`define OP_BEQL    6'b010100 // Likely forms set opcode bit 4
`define OP_BNEL    6'b010101
`define OP_BLEZL   6'b010110
`define OP_BGTZL   6'b010111
`define OP_LB      6'b100000
`define OP_LH      6'b100001
`define OP_LWL     6'b100010
`define OP_LW      6'b100011
`define OP_LBU     6'b100100
`define OP_LHU     6'b100101
`define OP_LWR     6'b100110
`define OP_SB      6'b101000
`define OP_SH      6'b101001
`define OP_SWL     6'b101010
`define OP_SW      6'b101011
`define OP_SWR     6'b101110

// SPECIAL funct codes
`define FN_SLL     6'b000000
`define FN_SRL     6'b000010
`define FN_SRA     6'b000011
`define FN_SLLV    6'b000100
`define FN_SRLV    6'b000110
`define FN_SRAV    6'b000111
`define FN_JR      6'b001000
`define FN_JALR    6'b001001
`define FN_SYSCALL 6'b001100
`define FN_BREAK   6'b001101
`define FN_MFHI    6'b010000
`define FN_MTHI    6'b010001
`define FN_MFLO    6'b010010
`define FN_MTLO    6'b010011
`define FN_MULT    6'b011000
`define FN_MULTU   6'b011001
`define FN_DIV     6'b011010
`define FN_DIVU    6'b011011
`define FN_ADD     6'b100000
`define FN_ADDU    6'b100001
`define FN_SUB     6'b100010
`define FN_SUBU    6'b100011
`define FN_AND     6'b100100
`define FN_OR      6'b100101
`define FN_XOR     6'b100110
`define FN_NOR     6'b100111
`define FN_SLT     6'b101010
`define FN_SLTU    6'b101011

// REGIMM rt codes: bit 0 GEZ, bit 1 likely, bit 4 link
`define RT_BLTZ    5'b00000
`define RT_BGEZ    5'b00001
`define RT_BLTZL   5'b00010
`define RT_BGEZL   5'b00011
`define RT_BLTZAL  5'b10000
`define RT_BGEZAL  5'b10001
`define RT_BLTZALL 5'b10010
`define RT_BGEZALL 5'b10011

`endif
